// File: Makefile
SIM = obj_dir/func_units_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module func_units_tb -Mdir obj_dir -o func_units_sim -f func_units.f

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// File: func_units.f
logic/fu_pkg.sv
logic/alu_decode.sv
logic/cond_eval.sv
logic/alu_execute.sv
logic/alu_result.sv
logic/func_units.sv
test/func_units_assertions.sv
test/func_units_tb.sv

// File: logic/alu_decode.sv
`timescale 1ns/10ps
`default_nettype none

module alu_decode #(
  parameter int GPR_SIZE = fu_pkg::DEF_GPR_SIZE,
  parameter int ROB_IDX_SIZE = fu_pkg::DEF_ROB_IDX_SIZE
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  input  logic                    in_start,
  input  logic                    in_stall,
  input  fu_pkg::alu_op_t         in_op,
  input  logic [GPR_SIZE-1:0]     in_val_a,
  input  logic [GPR_SIZE-1:0]     in_val_b,
  input  logic [ROB_IDX_SIZE-1:0] in_dst_rob_index,
  input  logic                    in_set_nzcv,
  input  fu_pkg::nzcv_t           in_nzcv,
  input  fu_pkg::cond_t           in_cond,
  output logic                    valid,
  output logic [GPR_SIZE-1:0]     val_a,
  output logic [GPR_SIZE-1:0]     val_b,
  output logic [ROB_IDX_SIZE-1:0] dst_rob_index,
  output logic                    set_nzcv,
  output fu_pkg::nzcv_t           nzcv,
  output fu_pkg::cond_t           cond,
  output logic                    is_sub,
  output logic                    invert_b,
  output fu_pkg::logic_sel_t      logic_sel,
  output logic                    is_csel,
  output fu_pkg::csel_mode_t      csel_mode
);

  logic                 dec_is_sub;
  logic                 dec_invert_b;
  fu_pkg::logic_sel_t   dec_logic_sel;
  logic                 dec_is_csel;
  fu_pkg::csel_mode_t   dec_csel_mode;

  // Opcode to control fields
  always_comb begin
    dec_is_sub = 1'b0;
    dec_invert_b = 1'b0;
    dec_logic_sel = fu_pkg::SEL_ZERO;
    dec_is_csel = 1'b0;
    dec_csel_mode = fu_pkg::CSEL_MODE_SEL;
    case (in_op)
      fu_pkg::ALU_OP_PLUS: dec_logic_sel = fu_pkg::SEL_ADD;
      fu_pkg::ALU_OP_MINUS: begin
        // A + ~B + 1
        dec_logic_sel = fu_pkg::SEL_ADD;
        dec_invert_b = 1'b1;
        dec_is_sub = 1'b1;
      end
      fu_pkg::ALU_OP_ORN: begin
        dec_logic_sel = fu_pkg::SEL_OR;
        dec_invert_b = 1'b1;
      end
      fu_pkg::ALU_OP_OR: dec_logic_sel = fu_pkg::SEL_OR;
      fu_pkg::ALU_OP_EOR: dec_logic_sel = fu_pkg::SEL_EOR;
      fu_pkg::ALU_OP_AND: dec_logic_sel = fu_pkg::SEL_AND;
      fu_pkg::ALU_OP_CSEL: dec_is_csel = 1'b1;
      fu_pkg::ALU_OP_CSINC: begin
        dec_is_csel = 1'b1;
        dec_csel_mode = fu_pkg::CSEL_MODE_INC;
      end
      fu_pkg::ALU_OP_CSINV: begin
        dec_is_csel = 1'b1;
        dec_csel_mode = fu_pkg::CSEL_MODE_INV;
      end
      fu_pkg::ALU_OP_CSNEG: begin
        dec_is_csel = 1'b1;
        dec_csel_mode = fu_pkg::CSEL_MODE_NEG;
      end
      // Unknown codes keep the zero selection
      default: dec_logic_sel = fu_pkg::SEL_ZERO;
    endcase
  end

  // Stage-1 valid, frozen under stall
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      valid <= 1'b0;
    end else if (!in_stall) begin
      valid <= in_start;
    end
  end

  // Operation fields load only on acceptance
  always_ff @(posedge in_clk) begin
    if (!in_stall && in_start) begin
      val_a <= in_val_a;
      val_b <= in_val_b;
      dst_rob_index <= in_dst_rob_index;
      set_nzcv <= in_set_nzcv;
      nzcv <= in_nzcv;
      cond <= in_cond;
      is_sub <= dec_is_sub;
      invert_b <= dec_invert_b;
      logic_sel <= dec_logic_sel;
      is_csel <= dec_is_csel;
      csel_mode <= dec_csel_mode;
    end
  end

endmodule

`default_nettype wire

// File: logic/alu_execute.sv
`timescale 1ns/10ps
`default_nettype none

module alu_execute #(
  parameter int GPR_SIZE = fu_pkg::DEF_GPR_SIZE
) (
  input  logic [GPR_SIZE-1:0] val_a,
  input  logic [GPR_SIZE-1:0] val_b,
  input  logic                is_sub,
  input  logic                invert_b,
  input  fu_pkg::logic_sel_t  logic_sel,
  input  logic                is_csel,
  input  fu_pkg::csel_mode_t  csel_mode,
  input  logic                holds,
  output logic [GPR_SIZE:0]   result_wide,
  output logic                carry,
  output logic                overflow,
  output logic                condition
);

  logic [GPR_SIZE-1:0] b_eff;
  logic [GPR_SIZE:0]   sum;
  logic                sum_ovf;
  logic [GPR_SIZE-1:0] csel_b;
  logic                csel_inc;
  logic [GPR_SIZE-1:0] csel_alt;
  logic                is_arith;

  // Second operand, inverted for SUB and ORN
  assign b_eff = invert_b ? ~val_b : val_b;

  // Carry-in of one completes the two's complement
  assign sum = {1'b0, val_a} + {1'b0, b_eff} + {{GPR_SIZE{1'b0}}, is_sub};

  // Same operand signs, different result sign
  assign sum_ovf = (val_a[GPR_SIZE-1] == b_eff[GPR_SIZE-1]) &&
                   (sum[GPR_SIZE-1] != val_a[GPR_SIZE-1]);

  // Fail path of the selects, shared incrementer
  // INV and NEG invert B, INC and NEG add one
  assign csel_b = (csel_mode == fu_pkg::CSEL_MODE_INV || csel_mode == fu_pkg::CSEL_MODE_NEG)
                  ? ~val_b : val_b;
  assign csel_inc = (csel_mode == fu_pkg::CSEL_MODE_INC || csel_mode == fu_pkg::CSEL_MODE_NEG);
  assign csel_alt = csel_b + {{(GPR_SIZE-1){1'b0}}, csel_inc};

  assign is_arith = !is_csel && (logic_sel == fu_pkg::SEL_ADD);

  always_comb begin
    if (is_csel) begin
      result_wide = {1'b0, (holds ? val_a : csel_alt)};
    end else begin
      case (logic_sel)
        fu_pkg::SEL_ADD: result_wide = sum;
        fu_pkg::SEL_OR: result_wide = {1'b0, val_a | b_eff};
        fu_pkg::SEL_EOR: result_wide = {1'b0, val_a ^ b_eff};
        fu_pkg::SEL_AND: result_wide = {1'b0, val_a & b_eff};
        default: result_wide = '0;
      endcase
    end
  end

  // C and V only meaningful for add and subtract
  assign carry = is_arith && sum[GPR_SIZE];
  assign overflow = is_arith && sum_ovf;

  // Condition result reported only for selects
  assign condition = is_csel && holds;

endmodule

`default_nettype wire

// File: logic/alu_result.sv
`timescale 1ns/10ps
`default_nettype none

module alu_result #(
  parameter int GPR_SIZE = fu_pkg::DEF_GPR_SIZE,
  parameter int ROB_IDX_SIZE = fu_pkg::DEF_ROB_IDX_SIZE
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  input  logic                    in_stall,
  input  logic                    valid,
  input  logic [GPR_SIZE:0]       result_wide,
  input  logic                    carry,
  input  logic                    overflow,
  input  logic                    condition,
  input  logic                    set_nzcv,
  input  fu_pkg::nzcv_t           nzcv,
  input  logic [ROB_IDX_SIZE-1:0] dst_rob_index,
  output logic                    done,
  output logic [GPR_SIZE-1:0]     value,
  output fu_pkg::nzcv_t           out_nzcv,
  output logic                    out_set_nzcv,
  output logic                    out_condition,
  output logic [ROB_IDX_SIZE-1:0] out_dst_rob_index
);

  logic [GPR_SIZE-1:0] res;
  fu_pkg::nzcv_t       calc_nzcv;
  fu_pkg::nzcv_t       next_nzcv;
  logic                load;

  assign res = result_wide[GPR_SIZE-1:0];

  // Flags from this result
  always_comb begin
    calc_nzcv = '0;
    calc_nzcv[fu_pkg::NZCV_N] = res[GPR_SIZE-1];
    calc_nzcv[fu_pkg::NZCV_Z] = (res == '0);
    calc_nzcv[fu_pkg::NZCV_C] = carry;
    calc_nzcv[fu_pkg::NZCV_V] = overflow;
  end

  // Incoming flags pass through when not setting
  assign next_nzcv = set_nzcv ? calc_nzcv : nzcv;

  // Capture only a live operation, hold otherwise
  assign load = valid && !in_stall;

  // Done pulse and reset-visible outputs
  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      done <= 1'b0;
      out_set_nzcv <= 1'b0;
      out_condition <= 1'b0;
    end else begin
      // No new pulse while the ROB stalls
      done <= load;
      if (load) begin
        out_set_nzcv <= set_nzcv;
        out_condition <= condition;
      end
    end
  end

  // Payload toward the ROB
  always_ff @(posedge in_clk) begin
    if (load) begin
      value <= res;
      out_nzcv <= next_nzcv;
      out_dst_rob_index <= dst_rob_index;
    end
  end

endmodule

`default_nettype wire

// File: logic/cond_eval.sv
`timescale 1ns/10ps
`default_nettype none

module cond_eval (
  input  fu_pkg::cond_t cond,
  input  fu_pkg::nzcv_t nzcv,
  output logic          holds
);

  logic n;
  logic z;
  logic c;
  logic v;

  // Split flags
  assign n = nzcv[fu_pkg::NZCV_N];
  assign z = nzcv[fu_pkg::NZCV_Z];
  assign c = nzcv[fu_pkg::NZCV_C];
  assign v = nzcv[fu_pkg::NZCV_V];

  always_comb begin
    case (cond)
      fu_pkg::COND_EQ: holds = z;
      fu_pkg::COND_NE: holds = !z;
      fu_pkg::COND_CS: holds = c;
      fu_pkg::COND_CC: holds = !c;
      fu_pkg::COND_MI: holds = n;
      fu_pkg::COND_PL: holds = !n;
      fu_pkg::COND_VS: holds = v;
      fu_pkg::COND_VC: holds = !v;
      // Unsigned higher / lower or same
      fu_pkg::COND_HI: holds = c && !z;
      fu_pkg::COND_LS: holds = !c || z;
      // Signed compares
      fu_pkg::COND_GE: holds = (n == v);
      fu_pkg::COND_LT: holds = (n != v);
      fu_pkg::COND_GT: holds = !z && (n == v);
      fu_pkg::COND_LE: holds = z || (n != v);
      // AL and NV both always true
      default: holds = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/fu_pkg.sv
`default_nettype none

package fu_pkg;

  // Default datapath widths
  localparam int DEF_GPR_SIZE = 64;
  localparam int DEF_ROB_IDX_SIZE = 6;

  // ALU opcode as sent by the reservation station
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_OP_PLUS = 4'd0;
  localparam alu_op_t ALU_OP_MINUS = 4'd1;
  localparam alu_op_t ALU_OP_ORN = 4'd2;
  localparam alu_op_t ALU_OP_OR = 4'd3;
  localparam alu_op_t ALU_OP_EOR = 4'd4;
  localparam alu_op_t ALU_OP_AND = 4'd5;
  localparam alu_op_t ALU_OP_CSEL = 4'd6;
  localparam alu_op_t ALU_OP_CSINC = 4'd7;
  localparam alu_op_t ALU_OP_CSINV = 4'd8;
  localparam alu_op_t ALU_OP_CSNEG = 4'd9;

  // ARM condition codes, standard encoding
  typedef logic [3:0] cond_t;

  localparam cond_t COND_EQ = 4'h0;
  localparam cond_t COND_NE = 4'h1;
  localparam cond_t COND_CS = 4'h2;
  localparam cond_t COND_CC = 4'h3;
  localparam cond_t COND_MI = 4'h4;
  localparam cond_t COND_PL = 4'h5;
  localparam cond_t COND_VS = 4'h6;
  localparam cond_t COND_VC = 4'h7;
  localparam cond_t COND_HI = 4'h8;
  localparam cond_t COND_LS = 4'h9;
  localparam cond_t COND_GE = 4'hA;
  localparam cond_t COND_LT = 4'hB;
  localparam cond_t COND_GT = 4'hC;
  localparam cond_t COND_LE = 4'hD;
  localparam cond_t COND_AL = 4'hE;
  localparam cond_t COND_NV = 4'hF;

  // Flags, N in bit 3 down to V in bit 0
  typedef logic [3:0] nzcv_t;

  localparam int NZCV_N = 3;
  localparam int NZCV_Z = 2;
  localparam int NZCV_C = 1;
  localparam int NZCV_V = 0;

  // Result source chosen by decode
  typedef logic [2:0] logic_sel_t;

  localparam logic_sel_t SEL_ZERO = 3'd0;
  localparam logic_sel_t SEL_ADD = 3'd1;
  localparam logic_sel_t SEL_OR = 3'd2;
  localparam logic_sel_t SEL_EOR = 3'd3;
  localparam logic_sel_t SEL_AND = 3'd4;

  // Value used by a conditional select when the condition fails
  typedef logic [1:0] csel_mode_t;

  localparam csel_mode_t CSEL_MODE_SEL = 2'd0;
  localparam csel_mode_t CSEL_MODE_INC = 2'd1;
  localparam csel_mode_t CSEL_MODE_INV = 2'd2;
  localparam csel_mode_t CSEL_MODE_NEG = 2'd3;

endpackage

`default_nettype wire

// File: logic/func_units.sv
`timescale 1ns/10ps
`default_nettype none

module func_units #(
  parameter int GPR_SIZE = fu_pkg::DEF_GPR_SIZE,
  parameter int ROB_IDX_SIZE = fu_pkg::DEF_ROB_IDX_SIZE
) (
  input  logic                    in_clk,
  input  logic                    in_rst_n,
  // From reservation station
  input  logic                    in_rs_alu_start,
  input  fu_pkg::alu_op_t         in_rs_alu_op,
  input  logic [GPR_SIZE-1:0]     in_rs_alu_val_a,
  input  logic [GPR_SIZE-1:0]     in_rs_alu_val_b,
  input  logic [ROB_IDX_SIZE-1:0] in_rs_alu_dst_rob_index,
  input  logic                    in_rs_alu_set_nzcv,
  input  fu_pkg::nzcv_t           in_rs_alu_nzcv,
  input  fu_pkg::cond_t           in_rs_alu_cond,
  // From ROB
  input  logic                    in_rob_stall,
  // To reservation station
  output logic                    out_rs_alu_ready,
  output logic                    out_rs_ls_ready,
  // To ROB
  output logic                    out_rob_done,
  output logic [ROB_IDX_SIZE-1:0] out_rob_dst_rob_index,
  output logic [GPR_SIZE-1:0]     out_rob_value,
  output logic                    out_rob_set_nzcv,
  output fu_pkg::nzcv_t           out_rob_nzcv,
  output logic                    out_alu_condition
);

  // Stage-1 fields
  logic                    s1_valid;
  logic [GPR_SIZE-1:0]     s1_val_a;
  logic [GPR_SIZE-1:0]     s1_val_b;
  logic [ROB_IDX_SIZE-1:0] s1_dst_rob_index;
  logic                    s1_set_nzcv;
  fu_pkg::nzcv_t           s1_nzcv;
  fu_pkg::cond_t           s1_cond;
  logic                    s1_is_sub;
  logic                    s1_invert_b;
  fu_pkg::logic_sel_t      s1_logic_sel;
  logic                    s1_is_csel;
  fu_pkg::csel_mode_t      s1_csel_mode;

  // Execute outputs
  logic                    cond_holds;
  logic [GPR_SIZE:0]       ex_result_wide;
  logic                    ex_carry;
  logic                    ex_overflow;
  logic                    ex_condition;

  // Ready whenever the ROB accepts results, no load/store unit yet
  assign out_rs_alu_ready = !in_rob_stall;
  assign out_rs_ls_ready = 1'b0;

  alu_decode #(
    .GPR_SIZE(GPR_SIZE),
    .ROB_IDX_SIZE(ROB_IDX_SIZE)
  ) u_decode (
    .in_clk(in_clk),
    .in_rst_n(in_rst_n),
    .in_start(in_rs_alu_start),
    .in_stall(in_rob_stall),
    .in_op(in_rs_alu_op),
    .in_val_a(in_rs_alu_val_a),
    .in_val_b(in_rs_alu_val_b),
    .in_dst_rob_index(in_rs_alu_dst_rob_index),
    .in_set_nzcv(in_rs_alu_set_nzcv),
    .in_nzcv(in_rs_alu_nzcv),
    .in_cond(in_rs_alu_cond),
    .valid(s1_valid),
    .val_a(s1_val_a),
    .val_b(s1_val_b),
    .dst_rob_index(s1_dst_rob_index),
    .set_nzcv(s1_set_nzcv),
    .nzcv(s1_nzcv),
    .cond(s1_cond),
    .is_sub(s1_is_sub),
    .invert_b(s1_invert_b),
    .logic_sel(s1_logic_sel),
    .is_csel(s1_is_csel),
    .csel_mode(s1_csel_mode)
  );

  // Condition judged on the flags sent with the operation
  cond_eval u_cond (
    .cond(s1_cond),
    .nzcv(s1_nzcv),
    .holds(cond_holds)
  );

  alu_execute #(
    .GPR_SIZE(GPR_SIZE)
  ) u_execute (
    .val_a(s1_val_a),
    .val_b(s1_val_b),
    .is_sub(s1_is_sub),
    .invert_b(s1_invert_b),
    .logic_sel(s1_logic_sel),
    .is_csel(s1_is_csel),
    .csel_mode(s1_csel_mode),
    .holds(cond_holds),
    .result_wide(ex_result_wide),
    .carry(ex_carry),
    .overflow(ex_overflow),
    .condition(ex_condition)
  );

  alu_result #(
    .GPR_SIZE(GPR_SIZE),
    .ROB_IDX_SIZE(ROB_IDX_SIZE)
  ) u_result (
    .in_clk(in_clk),
    .in_rst_n(in_rst_n),
    .in_stall(in_rob_stall),
    .valid(s1_valid),
    .result_wide(ex_result_wide),
    .carry(ex_carry),
    .overflow(ex_overflow),
    .condition(ex_condition),
    .set_nzcv(s1_set_nzcv),
    .nzcv(s1_nzcv),
    .dst_rob_index(s1_dst_rob_index),
    .done(out_rob_done),
    .value(out_rob_value),
    .out_nzcv(out_rob_nzcv),
    .out_set_nzcv(out_rob_set_nzcv),
    .out_condition(out_alu_condition),
    .out_dst_rob_index(out_rob_dst_rob_index)
  );

endmodule

`default_nettype wire

// File: test/func_units_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module func_units_assertions #(
  parameter int GPR_SIZE = fu_pkg::DEF_GPR_SIZE,
  parameter int ROB_IDX_SIZE = fu_pkg::DEF_ROB_IDX_SIZE
) (
  input logic                    in_clk,
  input logic                    in_rst_n,
  input logic                    in_stall,
  input logic                    done,
  input logic [GPR_SIZE-1:0]     value,
  input fu_pkg::nzcv_t           out_nzcv,
  input logic                    out_set_nzcv,
  input logic                    out_condition,
  input logic [ROB_IDX_SIZE-1:0] out_dst_rob_index
);

  // Cleared outputs when reset lifts
  a_reset_clear: assert property (@(posedge in_clk)
    $rose(in_rst_n) |-> !done && !out_set_nzcv && !out_condition)
    else $error("done or flag outputs not cleared by reset");

  // Stall sampled at an edge blocks the pulse from that edge
  a_no_done_after_stall: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    in_stall |=> !done)
    else $error("done rose after a stalled cycle");

  // Payload frozen under stall, once something was loaded
  a_hold_on_stall: assert property (@(posedge in_clk) disable iff (!in_rst_n)
    in_stall && !$isunknown(value) |=>
      $stable(value) && $stable(out_nzcv) && $stable(out_dst_rob_index) &&
      $stable(out_set_nzcv) && $stable(out_condition))
    else $error("result outputs changed during stall");

endmodule

`default_nettype wire

// File: test/func_units_tb.sv
`timescale 1ns/10ps
`default_nettype none

module func_units_tb;

  localparam int GPR_SIZE = fu_pkg::DEF_GPR_SIZE;
  localparam int ROB_IDX_SIZE = fu_pkg::DEF_ROB_IDX_SIZE;
  localparam int NUM_RANDOM = 3000;
  localparam int DRAIN_LIMIT = 50;
  localparam logic [GPR_SIZE-1:0] ONE = 1;

  logic                    in_clk;
  logic                    in_rst_n;
  logic                    in_rs_alu_start;
  fu_pkg::alu_op_t         in_rs_alu_op;
  logic [GPR_SIZE-1:0]     in_rs_alu_val_a;
  logic [GPR_SIZE-1:0]     in_rs_alu_val_b;
  logic [ROB_IDX_SIZE-1:0] in_rs_alu_dst_rob_index;
  logic                    in_rs_alu_set_nzcv;
  fu_pkg::nzcv_t           in_rs_alu_nzcv;
  fu_pkg::cond_t           in_rs_alu_cond;
  logic                    in_rob_stall;
  logic                    out_rs_alu_ready;
  logic                    out_rs_ls_ready;
  logic                    out_rob_done;
  logic [ROB_IDX_SIZE-1:0] out_rob_dst_rob_index;
  logic [GPR_SIZE-1:0]     out_rob_value;
  logic                    out_rob_set_nzcv;
  fu_pkg::nzcv_t           out_rob_nzcv;
  logic                    out_alu_condition;

  // Scoreboard, one entry per accepted operation
  logic [GPR_SIZE-1:0]     exp_value_q[$];
  fu_pkg::nzcv_t           exp_nzcv_q[$];
  logic [ROB_IDX_SIZE-1:0] exp_index_q[$];
  logic                    exp_set_q[$];
  logic                    exp_cond_q[$];
  int                      exp_cycle_q[$];
  int                      exp_stall_q[$];

  int errors;
  int cycle;
  int stall_total;
  int accepted;
  int completed;
  logic [ROB_IDX_SIZE-1:0] next_index;

  func_units #(
    .GPR_SIZE(GPR_SIZE),
    .ROB_IDX_SIZE(ROB_IDX_SIZE)
  ) UUT (
    .in_clk(in_clk),
    .in_rst_n(in_rst_n),
    .in_rs_alu_start(in_rs_alu_start),
    .in_rs_alu_op(in_rs_alu_op),
    .in_rs_alu_val_a(in_rs_alu_val_a),
    .in_rs_alu_val_b(in_rs_alu_val_b),
    .in_rs_alu_dst_rob_index(in_rs_alu_dst_rob_index),
    .in_rs_alu_set_nzcv(in_rs_alu_set_nzcv),
    .in_rs_alu_nzcv(in_rs_alu_nzcv),
    .in_rs_alu_cond(in_rs_alu_cond),
    .in_rob_stall(in_rob_stall),
    .out_rs_alu_ready(out_rs_alu_ready),
    .out_rs_ls_ready(out_rs_ls_ready),
    .out_rob_done(out_rob_done),
    .out_rob_dst_rob_index(out_rob_dst_rob_index),
    .out_rob_value(out_rob_value),
    .out_rob_set_nzcv(out_rob_set_nzcv),
    .out_rob_nzcv(out_rob_nzcv),
    .out_alu_condition(out_alu_condition)
  );

  bind alu_result func_units_assertions #(
    .GPR_SIZE(GPR_SIZE),
    .ROB_IDX_SIZE(ROB_IDX_SIZE)
  ) u_assertions (
    .in_clk(in_clk),
    .in_rst_n(in_rst_n),
    .in_stall(in_stall),
    .done(done),
    .value(value),
    .out_nzcv(out_nzcv),
    .out_set_nzcv(out_set_nzcv),
    .out_condition(out_condition),
    .out_dst_rob_index(out_dst_rob_index)
  );

  initial begin
    in_clk = 1'b0;
    forever #50 in_clk = ~in_clk;
  end

  task automatic check_value(input logic [GPR_SIZE-1:0] got, input logic [GPR_SIZE-1:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_nzcv(input fu_pkg::nzcv_t got, input fu_pkg::nzcv_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_index(input logic [ROB_IDX_SIZE-1:0] got,
                             input logic [ROB_IDX_SIZE-1:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ARM ConditionHolds: bits 3:1 pick the test, bit 0 negates it
  function automatic logic cond_true(input fu_pkg::cond_t cond, input fu_pkg::nzcv_t f);
    logic r;
    case (cond[3:1])
      3'b000: r = f[2];
      3'b001: r = f[1];
      3'b010: r = f[3];
      3'b011: r = f[0];
      3'b100: r = f[1] && !f[2];
      3'b101: r = (f[3] == f[0]);
      3'b110: r = (f[3] == f[0]) && !f[2];
      default: r = 1'b1;
    endcase
    if (cond[0] && cond != fu_pkg::COND_NV) begin
      r = !r;
    end
    return r;
  endfunction

  // Reference model, queued at acceptance
  task automatic push_expected(input fu_pkg::alu_op_t op, input logic [GPR_SIZE-1:0] a,
                               input logic [GPR_SIZE-1:0] b, input logic set,
                               input fu_pkg::nzcv_t nzcv_in, input fu_pkg::cond_t cond);
    logic [GPR_SIZE-1:0] res;
    logic c;
    logic v;
    logic ok;
    logic sel_op;
    res = '0;
    c = 1'b0;
    v = 1'b0;
    ok = cond_true(cond, nzcv_in);
    sel_op = 1'b0;
    case (op)
      fu_pkg::ALU_OP_PLUS: begin
        {c, res} = {1'b0, a} + {1'b0, b};
        v = (a[GPR_SIZE-1] == b[GPR_SIZE-1]) && (res[GPR_SIZE-1] != a[GPR_SIZE-1]);
      end
      fu_pkg::ALU_OP_MINUS: begin
        // Carry set when no borrow
        res = a - b;
        c = (a >= b);
        v = (a[GPR_SIZE-1] != b[GPR_SIZE-1]) && (res[GPR_SIZE-1] != a[GPR_SIZE-1]);
      end
      fu_pkg::ALU_OP_ORN: res = a | ~b;
      fu_pkg::ALU_OP_OR: res = a | b;
      fu_pkg::ALU_OP_EOR: res = a ^ b;
      fu_pkg::ALU_OP_AND: res = a & b;
      fu_pkg::ALU_OP_CSEL: res = ok ? a : b;
      fu_pkg::ALU_OP_CSINC: res = ok ? a : (b + ONE);
      fu_pkg::ALU_OP_CSINV: res = ok ? a : ~b;
      fu_pkg::ALU_OP_CSNEG: res = ok ? a : -b;
      default: res = '0;
    endcase
    sel_op = (op >= fu_pkg::ALU_OP_CSEL) && (op <= fu_pkg::ALU_OP_CSNEG);
    exp_value_q.push_back(res);
    exp_nzcv_q.push_back(set ? {res[GPR_SIZE-1], res == '0, c, v} : nzcv_in);
    exp_index_q.push_back(next_index);
    exp_set_q.push_back(set);
    exp_cond_q.push_back(sel_op && ok);
    exp_cycle_q.push_back(cycle);
    exp_stall_q.push_back(stall_total);
  endtask

  // One cycle of stimulus, 5 ns after the edge
  task automatic drive_op(input logic start, input logic stall, input fu_pkg::alu_op_t op,
                          input logic [GPR_SIZE-1:0] a, input logic [GPR_SIZE-1:0] b,
                          input logic set, input fu_pkg::nzcv_t f, input fu_pkg::cond_t cond);
    @(posedge in_clk);
    #5;
    cycle++;
    if (stall) begin
      stall_total++;
    end
    in_rob_stall = stall;
    // RS never strobes while ready is low
    in_rs_alu_start = start && !stall;
    in_rs_alu_op = op;
    in_rs_alu_val_a = a;
    in_rs_alu_val_b = b;
    in_rs_alu_dst_rob_index = next_index;
    in_rs_alu_set_nzcv = set;
    in_rs_alu_nzcv = f;
    in_rs_alu_cond = cond;
    if (start && !stall) begin
      push_expected(op, a, b, set, f, cond);
      accepted++;
      next_index++;
    end
  endtask

  task automatic drive_idle();
    drive_op(1'b0, 1'b0, fu_pkg::ALU_OP_PLUS, '0, '0, 1'b0, '0, fu_pkg::COND_AL);
  endtask

  function automatic logic random_bit();
    return ($urandom % 2) == 1;
  endfunction

  // Edge values weighted in
  function automatic logic [GPR_SIZE-1:0] random_operand();
    int pick;
    pick = $urandom % 8;
    case (pick)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(GPR_SIZE-1){1'b0}}};
      3: return {1'b0, {(GPR_SIZE-1){1'b1}}};
      4: return ONE;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  // Mostly legal opcodes, a few unknown ones
  function automatic fu_pkg::alu_op_t random_op();
    int pick;
    pick = $urandom % 20;
    if (pick < 18) begin
      return fu_pkg::alu_op_t'(pick % 10);
    end
    return fu_pkg::alu_op_t'(10 + ($urandom % 6));
  endfunction

  task automatic report_result();
    $display("Accepted %0d, completed %0d, errors %0d", accepted, completed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // Response monitor, sampled mid-cycle
  initial begin
    logic prev_stall;
    int expect_cycle;
    prev_stall = 1'b0;
    forever begin
      @(negedge in_clk);
      if (in_rst_n) begin
        check_flag(out_rs_alu_ready, !in_rob_stall, "out_rs_alu_ready");
        check_flag(out_rs_ls_ready, 1'b0, "out_rs_ls_ready");
        if (out_rob_done && prev_stall) begin
          errors++;
          $display("Done pulse at %0t right after a stalled cycle", $time);
        end
        if (out_rob_done && exp_value_q.size() == 0) begin
          errors++;
          $display("Done pulse at %0t with no operation outstanding", $time);
        end else if (out_rob_done) begin
          check_value(out_rob_value, exp_value_q.pop_front(), "out_rob_value");
          check_nzcv(out_rob_nzcv, exp_nzcv_q.pop_front(), "out_rob_nzcv");
          check_index(out_rob_dst_rob_index, exp_index_q.pop_front(), "out_rob_dst_rob_index");
          check_flag(out_rob_set_nzcv, exp_set_q.pop_front(), "out_rob_set_nzcv");
          check_flag(out_alu_condition, exp_cond_q.pop_front(), "out_alu_condition");
          // Two cycles after start plus one per stalled cycle in between
          expect_cycle = exp_cycle_q.pop_front() + 2 + (stall_total - int'(in_rob_stall))
                         - exp_stall_q.pop_front();
          if (cycle != expect_cycle) begin
            errors++;
            $display("Done pulse came in cycle %0d, expected cycle %0d", cycle, expect_cycle);
          end
          completed++;
        end
      end
      prev_stall = in_rob_stall;
    end
  end

  initial begin
    logic stall_now;
    int drain;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h2949));
    errors = 0;
    cycle = 0;
    stall_total = 0;
    accepted = 0;
    completed = 0;
    next_index = '0;
    in_rst_n = 1'b0;
    in_rs_alu_start = 1'b0;
    in_rs_alu_op = fu_pkg::ALU_OP_PLUS;
    in_rs_alu_val_a = '0;
    in_rs_alu_val_b = '0;
    in_rs_alu_dst_rob_index = '0;
    in_rs_alu_set_nzcv = 1'b0;
    in_rs_alu_nzcv = '0;
    in_rs_alu_cond = fu_pkg::COND_AL;
    in_rob_stall = 1'b0;
    repeat (2) @(posedge in_clk);
    #5;
    in_rst_n = 1'b1;
    @(negedge in_clk);
    check_flag(out_rob_done, 1'b0, "out_rob_done after reset");
    check_flag(out_alu_condition, 1'b0, "out_alu_condition after reset");
    check_flag(out_rob_set_nzcv, 1'b0, "out_rob_set_nzcv after reset");
    check_flag(out_rs_ls_ready, 1'b0, "out_rs_ls_ready after reset");
    // Every select mode against every condition, back to back
    for (int m = 0; m < 4; m++) begin
      for (int c = 0; c < 32; c++) begin
        drive_op(1'b1, 1'b0, fu_pkg::alu_op_t'(fu_pkg::ALU_OP_CSEL + m), random_operand(),
                 random_operand(), random_bit(), fu_pkg::nzcv_t'($urandom),
                 fu_pkg::cond_t'(c % 16));
      end
    end
    // Random traffic with stall bursts
    stall_now = 1'b0;
    repeat (NUM_RANDOM) begin
      stall_now = stall_now ? random_bit() : (($urandom % 8) == 0);
      drive_op(($urandom % 4) != 0, stall_now, random_op(), random_operand(), random_operand(),
               random_bit(), fu_pkg::nzcv_t'($urandom), fu_pkg::cond_t'($urandom));
    end
    drain = 0;
    while (exp_value_q.size() != 0 && drain < DRAIN_LIMIT) begin
      drive_idle();
      drain++;
    end
    if (exp_value_q.size() != 0) begin
      errors++;
      $display("Timed out with %0d operations never completed", exp_value_q.size());
    end
    // Quiet tail, any stray done pulse is caught by the monitor
    repeat (4) drive_idle();
    report_result();
  end

endmodule

`default_nettype wire
